/* sim.f */
hw/shell_pkg.sv
hw/csr_bank.sv
hw/mem_window.sv
hw/perf_counters.sv
hw/io_fifo.sv
hw/zynq_core_shell.sv
test/shell_assert.sv
test/tb_zynq_core_shell.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator; the exit status reports the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f sim.f \
   --top-module tb_zynq_core_shell -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/Vtb_zynq_core_shell 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qF "** PASS **"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* test/tb_zynq_core_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_core_shell
   import shell_pkg::*;
   ();

   localparam int FIFO_DEPTH = 8;
   localparam int TIMEOUT    = 20;

   localparam logic [31:0] RD_EXACT = 32'd0;
   localparam logic [31:0] RD_MIN   = 32'd1;
   localparam logic [31:0] RD_HELD  = 32'd2;

   typedef enum {ST_WR, ST_RD, ST_IO, ST_PROBE, ST_PULSE, ST_STAT} step_kind_e;

   // a and b carry stimulus, e0 to e3 expected values or step options
   typedef struct {
      step_kind_e  kind;
      reg_addr_e   ra;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] e0;
      logic [31:0] e1;
      logic [31:0] e2;
      logic [31:0] e3;
   } step_t;

   logic              clk_i = 1'b0;
   logic              reset_i;
   reg_req_t          reg_req_i;
   logic [REG_W-1:0]  reg_rdata_o;
   logic              reg_rvalid_o;
   logic              sys_reset_o;
   logic              core_reset_o;
   logic [ADDR_W-1:0] host_awaddr_i;
   logic [ADDR_W-1:0] host_araddr_i;
   logic [ADDR_W-1:0] core_awaddr_o;
   logic [ADDR_W-1:0] core_araddr_o;
   logic [ADDR_W-1:0] dram_req_awaddr_i;
   logic [ADDR_W-1:0] dram_req_araddr_i;
   logic              dram_awvalid_i;
   logic              dram_arvalid_i;
   logic [ADDR_W-1:0] dram_awaddr_o;
   logic [ADDR_W-1:0] dram_araddr_o;
   logic              instr_retired_i;
   io_req_t           io_req_i;
   logic              io_ready_o;

   logic [31:0]       lfsr_state = 32'hc46812a3;
   logic [31:0]       base_m;
   logic [127:0]      use_map;
   logic [31:0]       io_q[$];
   logic [31:0]       held;
   step_t             steps[$];

   zynq_core_shell #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_zynq_core_shell (.*);

   bind zynq_core_shell shell_assert u_shell_assert (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .reg_req_i    (reg_req_i),
      .rvalid_i     (reg_rvalid_o),
      .sys_reset_i  (sys_reset_o),
      .core_reset_i (core_reset_o),
      .io_ready_i   (io_ready_o),
      .io_count_i   (io_count)
   );

   always #20 clk_i = ~clk_i;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // Host window 0 goes to core 0x8000_0000, host 0x2000_0000 to core 0
   function automatic logic [31:0] core_addr_of(input logic [31:0] h);
      return (h & 32'h0fff_ffff) | (h[29] ? 32'h0000_0000 : 32'h8000_0000);
   endfunction

   function automatic logic [31:0] dram_addr_of(input logic [31:0] c, input logic [31:0] base);
      return c + 32'h8000_0000 + base;
   endfunction

   function automatic logic [31:0] io_word_of(input logic [31:0] addr, input logic [7:0] data);
      return 32'h8000_0000 | {1'b0, addr[22:0], 8'h00} | {24'h0, data};
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp)
         stop_run($sformatf("Mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp));
   endtask

   task automatic add_step(input step_kind_e k, input reg_addr_e ra, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] e0, input logic [31:0] e1,
                           input logic [31:0] e2, input logic [31:0] e3);
      step_t s;
      s.kind = k;
      s.ra   = ra;
      s.a    = a;
      s.b    = b;
      s.e0   = e0;
      s.e1   = e1;
      s.e2   = e2;
      s.e3   = e3;
      steps.push_back(s);
   endtask

   task automatic add_write(input reg_addr_e ra, input logic [31:0] d);
      add_step(ST_WR, ra, d, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
   endtask

   task automatic add_read(input reg_addr_e ra, input logic [31:0] e, input logic [31:0] mode);
      add_step(ST_RD, ra, 32'd0, 32'd0, e, mode, 32'd0, 32'd0);
   endtask

   // Expected {sys_reset_o, core_reset_o, io_ready_o}
   task automatic add_status(input logic [31:0] e);
      add_step(ST_STAT, REG_SYS_RUN, 32'd0, 32'd0, e, 32'd0, 32'd0, 32'd0);
   endtask

   // With drain set the host pops the head word while the request waits on a full FIFO
   task automatic add_io(input logic we, input logic drain);
      logic [31:0] addr;
      logic [7:0]  data;
      logic [31:0] head;
      addr = rand_bits(32);
      data = 8'(rand_bits(8));
      head = 32'd0;
      if (drain)
         head = io_q.pop_front();
      add_step(ST_IO, REG_SYS_RUN, addr, {24'h0, data}, {31'b0, we}, {31'b0, drain}, head,
               32'd0);
      if (we)
         io_q.push_back(io_word_of(addr, data));
   endtask

   // An empty FIFO reads as zero
   task automatic add_pop();
      if (io_q.size() == 0)
         add_read(REG_IO_DATA, 32'd0, RD_EXACT);
      else
         add_read(REG_IO_DATA, io_q.pop_front(), RD_EXACT);
   endtask

   task automatic build_table();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] n;
      logic [31:0] bit_r;
      add_status(32'd7);
      for (int i = 0; i < 18; i++)
         add_read(reg_addr_e'(i[4:0]), 32'd0, RD_EXACT);

      base_m = rand_bits(32);
      add_write(REG_DRAM_BASE, base_m);
      add_read(REG_DRAM_BASE, base_m, RD_EXACT);
      a = rand_bits(32) | 32'd1;
      add_write(REG_SYS_RUN, a);
      add_read(REG_SYS_RUN, a, RD_EXACT);
      a = rand_bits(32) | 32'd1;
      add_write(REG_CORE_RUN, a);
      add_read(REG_CORE_RUN, a, RD_EXACT);
      a = rand_bits(32) & ~32'd1;
      add_write(REG_COUNT_EN, a);
      add_read(REG_COUNT_EN, a, RD_EXACT);
      add_status(32'd1);
      add_write(REG_MEM_USE0, rand_bits(32));
      add_read(REG_MEM_USE0, 32'd0, RD_EXACT);
      add_write(REG_IO_COUNT, rand_bits(32));
      add_read(REG_IO_COUNT, 32'd0, RD_EXACT);
      add_write(REG_CYCLE_HI, rand_bits(32));
      add_read(REG_CYCLE_HI, 32'd0, RD_EXACT);

      add_step(ST_PROBE, REG_SYS_RUN, 32'h0000_0040, 32'h2000_0040, 32'h8000_0040,
               32'h0000_0040, dram_addr_of(32'h2000_0040, base_m),
               dram_addr_of(32'h0000_0040, base_m));
      for (int i = 0; i < 8; i++)
      begin
         if (i == 4)
         begin
            base_m = rand_bits(32);
            add_write(REG_DRAM_BASE, base_m);
         end
         a = rand_bits(32);
         b = rand_bits(32);
         add_step(ST_PROBE, REG_SYS_RUN, a, b, core_addr_of(a), core_addr_of(b),
                  dram_addr_of(b, base_m), dram_addr_of(a, base_m));
      end

      use_map = '0;
      for (int i = 0; i < 7; i++)
      begin
         a = rand_bits(32);
         b = rand_bits(32);
         // The last pulse is a write alone whose read address must not mark
         add_step(ST_PULSE, REG_SYS_RUN, a, b, (i == 6) ? 32'd2 : 32'd6, 32'd0, 32'd0, 32'd0);
         use_map[a[29:23]] = 1'b1;
         if (i != 6)
            use_map[b[29:23]] = 1'b1;
      end
      for (int k = 0; k < 4; k++)
         add_read(reg_addr_e'(5'd8 + k[4:0]), use_map[k*32 +: 32], RD_EXACT);
      add_write(REG_SYS_RUN, 32'd0);
      add_status(32'd5);
      add_write(REG_SYS_RUN, 32'd1);
      for (int k = 0; k < 4; k++)
         add_read(reg_addr_e'(5'd8 + k[4:0]), 32'd0, RD_EXACT);

      add_write(REG_COUNT_EN, 32'd1);
      n = 32'd0;
      for (int i = 0; i < 12; i++)
      begin
         bit_r = rand_bits(1);
         add_step(ST_PULSE, REG_SYS_RUN, 32'd0, 32'd0, bit_r, 32'd0, 32'd0, 32'd0);
         n = n + bit_r;
      end
      add_write(REG_COUNT_EN, 32'd0);
      add_read(REG_CYCLE_LO, n, RD_MIN);
      add_read(REG_INSTRET_LO, n, RD_EXACT);
      add_step(ST_PULSE, REG_SYS_RUN, 32'd0, 32'd0, 32'd1, 32'd0, 32'd0, 32'd0);
      add_step(ST_PULSE, REG_SYS_RUN, 32'd0, 32'd0, 32'd1, 32'd0, 32'd0, 32'd0);
      add_read(REG_CYCLE_LO, 32'd0, RD_HELD);
      add_read(REG_INSTRET_LO, n, RD_EXACT);
      add_read(REG_INSTRET_HI, 32'd0, RD_EXACT);

      add_io(1'b1, 1'b0);
      add_io(1'b0, 1'b0);
      add_io(1'b1, 1'b0);
      add_read(REG_IO_COUNT, 32'd2, RD_EXACT);
      add_pop();
      add_pop();
      add_pop();
      for (int i = 0; i < FIFO_DEPTH; i++)
         add_io(1'b1, 1'b0);
      add_status(32'd0);
      add_read(REG_IO_COUNT, 32'(FIFO_DEPTH), RD_EXACT);
      add_io(1'b1, 1'b1);
      add_read(REG_IO_COUNT, 32'(FIFO_DEPTH), RD_EXACT);
      add_pop();
      add_status(32'd1);
      add_io(1'b1, 1'b0);
      add_read(REG_IO_COUNT, 32'(FIFO_DEPTH), RD_EXACT);
      for (int i = 0; i <= FIFO_DEPTH; i++)
         add_pop();
      add_read(REG_IO_COUNT, 32'd0, RD_EXACT);
   endtask

   task automatic clear_inputs();
      reg_req_i         = '0;
      io_req_i          = '0;
      host_awaddr_i     = '0;
      host_araddr_i     = '0;
      dram_req_awaddr_i = '0;
      dram_req_araddr_i = '0;
      dram_awvalid_i    = 1'b0;
      dram_arvalid_i    = 1'b0;
      instr_retired_i   = 1'b0;
   endtask

   task automatic apply_step(input step_t s);
      int          t;
      logic [31:0] got;
      @(negedge clk_i);
      clear_inputs();
      case (s.kind)
         ST_WR:
         begin
            reg_req_i.we    = 1'b1;
            reg_req_i.addr  = s.ra;
            reg_req_i.wdata = s.a;
            @(posedge clk_i);
         end
         ST_RD:
         begin
            reg_req_i.re   = 1'b1;
            reg_req_i.addr = s.ra;
            @(posedge clk_i);
            @(negedge clk_i);
            reg_req_i.re = 1'b0;
            t = 0;
            while (!reg_rvalid_o)
            begin
               if (t == TIMEOUT)
                  stop_run("Timeout: reg_rvalid_o never rose after a register read");
               t++;
               @(negedge clk_i);
            end
            got = reg_rdata_o;
            if (s.e1 == RD_MIN)
            begin
               check({31'b0, (got >= s.e0) && (got != 32'd0)}, 32'd1, "cycle count too small");
               held = got;
            end
            else if (s.e1 == RD_HELD)
               check(got, held, "counter moved while counting was off");
            else
               check(got, s.e0, $sformatf("read of register %0d", s.ra));
         end
         ST_IO:
         begin
            io_req_i.v    = 1'b1;
            io_req_i.we   = s.e0[0];
            io_req_i.addr = s.a;
            io_req_i.data = s.b[7:0];
            // Request is held while the FIFO pushes back
            t = 0;
            while (!io_ready_o)
            begin
               if (t == TIMEOUT)
                  stop_run("Timeout: io_ready_o stayed low with an IO request pending");
               t++;
               reg_req_i.re   = s.e1[0] && (t == 3);
               reg_req_i.addr = REG_IO_DATA;
               @(negedge clk_i);
            end
            if (s.e1[0])
            begin
               check({31'b0, reg_rvalid_o}, 32'd1, "reg_rvalid_o after the drain read");
               check(reg_rdata_o, s.e2, "word popped under back-pressure");
            end
            reg_req_i.re = 1'b0;
            @(posedge clk_i);
         end
         ST_PROBE:
         begin
            host_awaddr_i     = s.a;
            host_araddr_i     = s.b;
            dram_req_awaddr_i = s.b;
            dram_req_araddr_i = s.a;
            #10;
            check(core_awaddr_o, s.e0, "core_awaddr_o");
            check(core_araddr_o, s.e1, "core_araddr_o");
            check(dram_awaddr_o, s.e2, "dram_awaddr_o");
            check(dram_araddr_o, s.e3, "dram_araddr_o");
         end
         ST_PULSE:
         begin
            instr_retired_i   = s.e0[0];
            dram_awvalid_i    = s.e0[1];
            dram_arvalid_i    = s.e0[2];
            dram_req_awaddr_i = s.a;
            dram_req_araddr_i = s.b;
            @(posedge clk_i);
         end
         default:
            check({29'b0, sys_reset_o, core_reset_o, io_ready_o}, s.e0, "reset and ready outputs");
      endcase
   endtask

   initial
   begin
      reset_i = 1'b1;
      clear_inputs();
      build_table();
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      foreach (steps[i])
         apply_step(steps[i]);
      @(negedge clk_i);
      clear_inputs();
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* test/shell_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module shell_assert
   import shell_pkg::*;
   (
   input  wire logic             clk_i,
   input  wire logic             reset_i,
   input  wire reg_req_t         reg_req_i,
   input  wire logic             rvalid_i,
   input  wire logic             sys_reset_i,
   input  wire logic             core_reset_i,
   input  wire logic             io_ready_i,
   input  wire logic [REG_W-1:0] io_count_i
   );

   // Read data returns exactly one cycle after the strobe
   rvalid_after_re: assert property (@(posedge clk_i) disable iff (reset_i)
      reg_req_i.re |=> rvalid_i)
      else $error("reg_rvalid_o missing one cycle after a read strobe");

   rvalid_only_after_re: assert property (@(posedge clk_i) disable iff (reset_i)
      !reg_req_i.re |=> !rvalid_i)
      else $error("reg_rvalid_o high without a read strobe");

   // A full FIFO takes no new word
   no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
      !io_ready_i |=> (io_count_i <= $past(io_count_i)))
      else $error("FIFO grew while io_ready_o was low");

   resets_follow_reset_i: assert property (@(posedge clk_i)
      reset_i |-> (sys_reset_i && core_reset_i))
      else $error("sys_reset_o or core_reset_o low while reset_i is high");

endmodule

`default_nettype wire

/* hw/zynq_core_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module zynq_core_shell
   import shell_pkg::*;
   #(
   parameter int FIFO_DEPTH = 8
   )
   (
   input  wire logic              clk_i,
   input  wire logic              reset_i,
   input  wire reg_req_t          reg_req_i,
   output logic [REG_W-1:0]       reg_rdata_o,
   output logic                   reg_rvalid_o,
   output logic                   sys_reset_o,
   output logic                   core_reset_o,
   input  wire logic [ADDR_W-1:0] host_awaddr_i,
   input  wire logic [ADDR_W-1:0] host_araddr_i,
   output logic [ADDR_W-1:0]      core_awaddr_o,
   output logic [ADDR_W-1:0]      core_araddr_o,
   input  wire logic [ADDR_W-1:0] dram_req_awaddr_i,
   input  wire logic [ADDR_W-1:0] dram_req_araddr_i,
   input  wire logic              dram_awvalid_i,
   input  wire logic              dram_arvalid_i,
   output logic [ADDR_W-1:0]      dram_awaddr_o,
   output logic [ADDR_W-1:0]      dram_araddr_o,
   input  wire logic              instr_retired_i,
   input  wire io_req_t           io_req_i,
   output logic                   io_ready_o
   );

   shell_ctrl_t           ctrl;
   logic [REGION_NUM-1:0] mem_use;
   logic [CNT_W-1:0]      cycle;
   logic [CNT_W-1:0]      instret;
   logic [REG_W-1:0]      io_data;
   logic [REG_W-1:0]      io_count;
   logic                  io_pop;

   csr_bank u_csr_bank (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .reg_req_i    (reg_req_i),
      .mem_use_i    (mem_use),
      .cycle_i      (cycle),
      .instret_i    (instret),
      .io_data_i    (io_data),
      .io_count_i   (io_count),
      .ctrl_o       (ctrl),
      .io_pop_o     (io_pop),
      .reg_rdata_o  (reg_rdata_o),
      .reg_rvalid_o (reg_rvalid_o)
   );

   mem_window u_mem_window (
      .clk_i             (clk_i),
      .ctrl_i            (ctrl),
      .host_awaddr_i     (host_awaddr_i),
      .host_araddr_i     (host_araddr_i),
      .core_awaddr_o     (core_awaddr_o),
      .core_araddr_o     (core_araddr_o),
      .dram_req_awaddr_i (dram_req_awaddr_i),
      .dram_req_araddr_i (dram_req_araddr_i),
      .dram_awvalid_i    (dram_awvalid_i),
      .dram_arvalid_i    (dram_arvalid_i),
      .dram_awaddr_o     (dram_awaddr_o),
      .dram_araddr_o     (dram_araddr_o),
      .mem_use_o         (mem_use)
   );

   perf_counters u_perf_counters (
      .clk_i           (clk_i),
      .ctrl_i          (ctrl),
      .instr_retired_i (instr_retired_i),
      .cycle_o         (cycle),
      .instret_o       (instret)
   );

   io_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_io_fifo (
      .clk_i      (clk_i),
      .ctrl_i     (ctrl),
      .io_req_i   (io_req_i),
      .io_ready_o (io_ready_o),
      .pop_i      (io_pop),
      .data_o     (io_data),
      .count_o    (io_count)
   );

   assign sys_reset_o  = ctrl.sys_reset;
   assign core_reset_o = ctrl.core_reset;

endmodule

`default_nettype wire

/* hw/io_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module io_fifo
   import shell_pkg::*;
   #(
   parameter int FIFO_DEPTH = 8
   )
   (
   input  wire logic        clk_i,
   input  wire shell_ctrl_t ctrl_i,
   input  wire io_req_t     io_req_i,
   output logic             io_ready_o,
   input  wire logic        pop_i,
   output logic [REG_W-1:0] data_o,
   output logic [REG_W-1:0] count_o
   );

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

   logic [REG_W-1:0] mem_r [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [OCC_W-1:0] count_r;
   logic             push;
   logic             pop;
   logic             empty;
   logic [REG_W-1:0] push_word;

   // Pointers wrap at FIFO_DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
   endfunction

   assign empty      = (count_r == '0);
   assign io_ready_o = (count_r < OCC_W'(FIFO_DEPTH));
   // IO reads are accepted here and go nowhere
   assign push       = io_req_i.v & io_req_i.we & io_ready_o;
   assign pop        = pop_i & ~empty;
   assign push_word  = {1'b1, io_req_i.addr[22:0], io_req_i.data};

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= push_word;
   end

   always_ff @(posedge clk_i)
   begin
      if (ctrl_i.sys_reset)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (pop)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         case ({push, pop})
            2'b10:   count_r <= count_r + OCC_W'(1);
            2'b01:   count_r <= count_r - OCC_W'(1);
            default: ;
         endcase
      end
   end

   assign data_o  = empty ? '0 : mem_r[rd_ptr_r];
   assign count_o = REG_W'(count_r);

endmodule

`default_nettype wire

/* hw/perf_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module perf_counters
   import shell_pkg::*;
   (
   input  wire logic        clk_i,
   input  wire shell_ctrl_t ctrl_i,
   input  wire logic        instr_retired_i,
   output logic [CNT_W-1:0] cycle_o,
   output logic [CNT_W-1:0] instret_o
   );

   logic [CNT_W-1:0] cycle_r;
   logic [CNT_W-1:0] instret_r;

   always_ff @(posedge clk_i)
   begin
      if (ctrl_i.core_reset)
      begin
         cycle_r   <= '0;
         instret_r <= '0;
      end
      else if (ctrl_i.count_en)
      begin
         cycle_r <= cycle_r + CNT_W'(1);
         if (instr_retired_i)
            instret_r <= instret_r + CNT_W'(1);
      end
   end

   assign cycle_o   = cycle_r;
   assign instret_o = instret_r;

endmodule

`default_nettype wire

/* hw/mem_window.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_window
   import shell_pkg::*;
   (
   input  wire logic                  clk_i,
   input  wire shell_ctrl_t           ctrl_i,
   input  wire logic [ADDR_W-1:0]     host_awaddr_i,
   input  wire logic [ADDR_W-1:0]     host_araddr_i,
   output logic [ADDR_W-1:0]          core_awaddr_o,
   output logic [ADDR_W-1:0]          core_araddr_o,
   input  wire logic [ADDR_W-1:0]     dram_req_awaddr_i,
   input  wire logic [ADDR_W-1:0]     dram_req_araddr_i,
   input  wire logic                  dram_awvalid_i,
   input  wire logic                  dram_arvalid_i,
   output logic [ADDR_W-1:0]          dram_awaddr_o,
   output logic [ADDR_W-1:0]          dram_araddr_o,
   output logic [REGION_NUM-1:0]      mem_use_o
   );

   // 8 MiB regions selected by core address bits 29:23
   localparam int REGION_LSB = 23;
   localparam int REGION_IW  = $clog2(REGION_NUM);

   logic [REGION_NUM-1:0] mem_use_r;
   logic [REGION_NUM-1:0] aw_hit;
   logic [REGION_NUM-1:0] ar_hit;

   // Host 0x0xxx_xxxx lands at core 0x8xxx_xxxx, host 0x2xxx_xxxx at core 0x0xxx_xxxx
   function automatic logic [ADDR_W-1:0] host_to_core(input logic [ADDR_W-1:0] addr);
      return {~addr[29], 3'b000, addr[27:0]};
   endfunction

   function automatic logic [ADDR_W-1:0] core_to_dram(input logic [ADDR_W-1:0] addr,
                                                      input logic [ADDR_W-1:0] base);
      return (addr ^ {1'b1, {(ADDR_W-1){1'b0}}}) + base;
   endfunction

   assign core_awaddr_o = host_to_core(host_awaddr_i);
   assign core_araddr_o = host_to_core(host_araddr_i);
   assign dram_awaddr_o = core_to_dram(dram_req_awaddr_i, ctrl_i.dram_base);
   assign dram_araddr_o = core_to_dram(dram_req_araddr_i, ctrl_i.dram_base);

   assign aw_hit = REGION_NUM'(dram_awvalid_i) << dram_req_awaddr_i[REGION_LSB +: REGION_IW];
   assign ar_hit = REGION_NUM'(dram_arvalid_i) << dram_req_araddr_i[REGION_LSB +: REGION_IW];

   // Sticky until the system is put back into reset
   always_ff @(posedge clk_i)
   begin
      if (ctrl_i.sys_reset)
         mem_use_r <= '0;
      else
         mem_use_r <= mem_use_r | aw_hit | ar_hit;
   end

   assign mem_use_o = mem_use_r;

endmodule

`default_nettype wire

/* hw/csr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_bank
   import shell_pkg::*;
   (
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,
   input  wire reg_req_t              reg_req_i,
   input  wire logic [REGION_NUM-1:0] mem_use_i,
   input  wire logic [CNT_W-1:0]      cycle_i,
   input  wire logic [CNT_W-1:0]      instret_i,
   input  wire logic [REG_W-1:0]      io_data_i,
   input  wire logic [REG_W-1:0]      io_count_i,
   output shell_ctrl_t                ctrl_o,
   output logic                       io_pop_o,
   output logic [REG_W-1:0]           reg_rdata_o,
   output logic                       reg_rvalid_o
   );

   logic [REG_W-1:0] sys_run_r;
   logic [REG_W-1:0] dram_base_r;
   logic [REG_W-1:0] core_run_r;
   logic [REG_W-1:0] count_en_r;
   logic [REG_W-1:0] rdata_d;

   // Writes to read-only addresses fall through
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         sys_run_r   <= '0;
         dram_base_r <= '0;
         core_run_r  <= '0;
         count_en_r  <= '0;
      end
      else if (reg_req_i.we)
      begin
         case (reg_req_i.addr)
            REG_SYS_RUN:   sys_run_r   <= reg_req_i.wdata;
            REG_DRAM_BASE: dram_base_r <= reg_req_i.wdata;
            REG_CORE_RUN:  core_run_r  <= reg_req_i.wdata;
            REG_COUNT_EN:  count_en_r  <= reg_req_i.wdata;
            default:       ;
         endcase
      end
   end

   // Both resets stay asserted until the host sets the run bits
   assign ctrl_o.sys_reset  = reset_i | ~sys_run_r[0];
   assign ctrl_o.core_reset = reset_i | ~core_run_r[0];
   assign ctrl_o.count_en   = count_en_r[0];
   assign ctrl_o.dram_base  = dram_base_r;

   assign io_pop_o = reg_req_i.re && (reg_req_i.addr == REG_IO_DATA);

   always_comb
   begin
      rdata_d = '0;
      case (reg_req_i.addr)
         REG_SYS_RUN:    rdata_d = sys_run_r;
         REG_DRAM_BASE:  rdata_d = dram_base_r;
         REG_CORE_RUN:   rdata_d = core_run_r;
         REG_COUNT_EN:   rdata_d = count_en_r;
         REG_MEM_USE0:   rdata_d = mem_use_i[0*REG_W +: REG_W];
         REG_MEM_USE1:   rdata_d = mem_use_i[1*REG_W +: REG_W];
         REG_MEM_USE2:   rdata_d = mem_use_i[2*REG_W +: REG_W];
         REG_MEM_USE3:   rdata_d = mem_use_i[3*REG_W +: REG_W];
         REG_CYCLE_LO:   rdata_d = cycle_i[0 +: REG_W];
         REG_CYCLE_HI:   rdata_d = cycle_i[REG_W +: REG_W];
         REG_INSTRET_LO: rdata_d = instret_i[0 +: REG_W];
         REG_INSTRET_HI: rdata_d = instret_i[REG_W +: REG_W];
         REG_IO_DATA:    rdata_d = io_data_i;
         REG_IO_COUNT:   rdata_d = io_count_i;
         default:        rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         reg_rvalid_o <= 1'b0;
      else
         reg_rvalid_o <= reg_req_i.re;
   end

   // Read data is captured on the strobe edge
   always_ff @(posedge clk_i)
   begin
      if (reg_req_i.re)
         reg_rdata_o <= rdata_d;
   end

endmodule

`default_nettype wire

/* hw/shell_pkg.sv */
`default_nettype none

package shell_pkg;

   localparam int REG_W      = 32;
   localparam int REG_ADDR_W = 5;
   localparam int ADDR_W     = 32;
   localparam int REGION_NUM = 128;
   localparam int CNT_W      = 64;

   // Host register word addresses
   typedef enum logic [REG_ADDR_W-1:0] {
      REG_SYS_RUN    = 5'd0,
      REG_DRAM_BASE  = 5'd2,
      REG_CORE_RUN   = 5'd3,
      REG_COUNT_EN   = 5'd4,
      REG_MEM_USE0   = 5'd8,
      REG_MEM_USE1   = 5'd9,
      REG_MEM_USE2   = 5'd10,
      REG_MEM_USE3   = 5'd11,
      REG_CYCLE_LO   = 5'd12,
      REG_CYCLE_HI   = 5'd13,
      REG_INSTRET_LO = 5'd14,
      REG_INSTRET_HI = 5'd15,
      REG_IO_DATA    = 5'd16,
      REG_IO_COUNT   = 5'd17
   } reg_addr_e;

   // One-cycle host request
   typedef struct packed {
      logic             we;
      logic             re;
      reg_addr_e        addr;
      logic [REG_W-1:0] wdata;
   } reg_req_t;

   typedef struct packed {
      logic              sys_reset;
      logic              core_reset;
      logic              count_en;
      logic [ADDR_W-1:0] dram_base;
   } shell_ctrl_t;

   // Memory-mapped IO request from the core
   typedef struct packed {
      logic              v;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        data;
   } io_req_t;

endpackage

`default_nettype wire
